/* verilog.f */
hdl/exec_pkg.sv
hdl/register_file.sv
hdl/forwarding_unit.sv
hdl/alu_stage.sv
hdl/retire_stage.sv
hdl/exec_top.sv
tests/exec_properties.sv
tests/exec_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute slice testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module exec_tb -f verilog.f
./obj_dir/Vexec_tb | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

/* tests/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    localparam int CHAIN_LEN   = 40;
    localparam int DIST_ROUNDS = 8;
    localparam int SAME_ROUNDS = 8;
    localparam int ZERO_ROUNDS = 10;
    localparam int BP_LEN      = 40;
    localparam int TOTAL_INSTR = 1 + CHAIN_LEN + DIST_ROUNDS * 6 + SAME_ROUNDS * 4
                                 + ZERO_ROUNDS * 2 + BP_LEN;
    localparam int TIMEOUT_CYCLES = TOTAL_INSTR * 20 + 200;

    logic             clk_i, rst_n_i;
    logic             issue_valid_i, issue_use_imm_i, issue_credit_o;
    alu_op_t          issue_op_i;
    logic [REG_W-1:0] issue_src_a_i, issue_src_b_i, issue_dest_i, result_dest_o;
    logic [XLEN-1:0]  issue_imm_i, result_data_o;
    logic             result_credit_i, result_valid_o;

    logic [XLEN-1:0]  arch_regs [NUM_REGS] = '{default: '0};  // Updated in issue order.
    logic [REG_W-1:0] exp_dest_q [$];
    logic [XLEN-1:0]  exp_data_q [$];
    logic [31:0]      rng_state = 32'd14;
    string            test_name;
    int issue_credits = QUEUE_DEPTH;
    int held_credits = 0;   // Output credits granted and not yet used.
    int grant_mode = 0;     // 0 withholds, 1 grants on demand, 2 grants at random.
    int error_count = 0;
    int failed_tests = 0;
    int assert_failures_seen = 0;
    int errors_at_start, results_seen, credit_pulses;

    exec_top dut (.*);

    bind retire_stage exec_properties u_exec_properties (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .alu_valid_i (alu_valid_i), .commit_valid_i (commit_valid_o),
        .writeback_valid_i (writeback_valid_o), .queue_count_i (queue_count),
        .result_valid_i (result_valid_o), .issue_credit_i (issue_credit_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Reference ALU. SLT looks at the signs first, then at the magnitudes.
    function automatic logic [XLEN-1:0] model_alu(alu_op_t op, logic [XLEN-1:0] a, b);
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + XLEN'(1);
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            default: return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
        endcase
    endfunction

    task automatic report_failure(string what);
        $display("Error in %s: %s", test_name, what);
        error_count++;
    endtask

    task automatic check_dest(logic [REG_W-1:0] expected, logic [REG_W-1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s result_dest expected %0d actual %0d",
                     test_name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_data(logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s result_data expected %08h actual %08h",
                     test_name, expected, actual);
            error_count++;
        end
    endtask

    // Samples the outputs mid-cycle, then drives the inputs for the next edge.
    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clk_i);
        if (result_valid_o) begin
            results_seen++;
            if (held_credits == 0)
                report_failure("result_valid_o high while the slice held no output credit");
            else
                held_credits--;
            if (exp_dest_q.size() == 0) begin
                report_failure("result_valid_o high with no result expected");
            end else begin
                check_dest(exp_dest_q.pop_front(), result_dest_o);
                check_data(exp_data_q.pop_front(), result_data_o);
            end
        end
        if (issue_credit_o) begin
            issue_credits++;
            credit_pulses++;
        end
        rnd = next_random();
        issue_valid_i = 1'b0;
        // The consumer never grants more credits than results it still expects.
        result_credit_i = (held_credits < exp_dest_q.size())
                          && (grant_mode == 1 || (grant_mode == 2 && rnd[0]));
        held_credits += int'(result_credit_i);
    endtask

    task automatic issue_instr(alu_op_t op, logic [REG_W-1:0] src_a, logic [REG_W-1:0] src_b,
                               logic [REG_W-1:0] dest, logic use_imm, logic [XLEN-1:0] imm);
        logic [XLEN-1:0] value;
        while (issue_credits == 0)
            next_cycle();
        value = model_alu(op, arch_regs[src_a], use_imm ? imm : arch_regs[src_b]);
        exp_dest_q.push_back(dest);
        exp_data_q.push_back(value);
        if (dest != '0)
            arch_regs[dest] = value;  // x0 keeps zero.
        issue_credits--;
        issue_valid_i   = 1'b1;
        issue_op_i      = op;
        issue_src_a_i   = src_a;
        issue_src_b_i   = src_b;
        issue_dest_i    = dest;
        issue_use_imm_i = use_imm;
        issue_imm_i     = imm;
        next_cycle();
    endtask

    task automatic run_test(string name, int kind, int count);
        logic [31:0]      r;
        logic [REG_W-1:0] d;
        logic [REG_W-1:0] prev;
        test_name       = name;
        errors_at_start = error_count;
        results_seen    = 0;
        credit_pulses   = 0;
        prev            = REG_W'(1);
        grant_mode      = (kind == 5) ? 0 : 1;
        if (kind == 5)
            repeat (10) next_cycle();
        for (int i = 0; i < count; i++) begin
            r = next_random();
            d = (r[7:3] == '0) ? REG_W'(1) : r[7:3];
            case (kind)
                1: begin  // Each instruction reads the one before it.
                    issue_instr((i < 8) ? alu_op_t'(i[2:0]) : alu_op_t'(r[2:0]), prev,
                                r[14] ? prev : r[12:8], d, r[13], next_random());
                    prev = d;
                end
                2: begin  // Gaps of 1 to 3 idle cycles give distances 2 to 4.
                    issue_instr(alu_op_t'(r[2:0]), r[20:16], r[25:21], d, r[26], next_random());
                    repeat (i % 3 + 1) next_cycle();
                    issue_instr(alu_op_t'(r[10:8]), d, d, r[15:11], 1'b0, '0);
                end
                3: begin
                    repeat (3) issue_instr(ADD, '0, '0, d, 1'b1, next_random());
                    issue_instr(alu_op_t'(r[2:0]), d, d, r[12:8], 1'b0, '0);
                end
                4: begin
                    issue_instr(alu_op_t'(r[2:0]), r[12:8], '0, '0, r[13], next_random());
                    issue_instr(alu_op_t'(r[16:14]), '0, '0, d, r[17], next_random());
                end
                default: issue_instr(alu_op_t'(r[2:0]), REG_W'(r[10:8]), REG_W'(r[13:11]),
                                     REG_W'(r[16:14]), r[17], next_random());
            endcase
            // With credits withheld every result has to stay queued.
            if (kind == 5 && grant_mode == 0 && (i == count - 1 || i == QUEUE_DEPTH - 1)) begin
                repeat (30) next_cycle();
                if (results_seen != 0 || credit_pulses != 0)
                    report_failure("output activity while output credits were withheld");
                grant_mode = 2;
            end
        end
        grant_mode = 1;
        while (exp_dest_q.size() != 0)
            next_cycle();
        repeat (3) next_cycle();
        if (credit_pulses != results_seen)
            report_failure("issue credit pulses do not match the number of results");
        if (issue_credits != QUEUE_DEPTH)
            report_failure("issuer did not get all its credits back");
        // Assertion failures in the bound checker count against this test.
        error_count += dut.u_retire_stage.u_exec_properties.failure_count - assert_failures_seen;
        assert_failures_seen = dut.u_retire_stage.u_exec_properties.failure_count;
        if (error_count != errors_at_start)
            failed_tests++;
        $display("Test %s: %0d results, %s", name, results_seen,
                 (error_count == errors_at_start) ? "ok" : "FAILED");
    endtask

    initial begin
        {rst_n_i, issue_valid_i, issue_use_imm_i, result_credit_i} = 4'b1000;
        {issue_src_a_i, issue_src_b_i, issue_dest_i, issue_imm_i} = '0;
        issue_op_i = ADD;
        #1 rst_n_i = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        run_test("reset_idle", 5, 1);
        run_test("alu_chain", 1, CHAIN_LEN);
        run_test("distance", 2, DIST_ROUNDS * 3);
        run_test("same_dest", 3, SAME_ROUNDS);
        run_test("reg_zero", 4, ZERO_ROUNDS);
        run_test("back_pressure", 5, BP_LEN);
        $display("Tests run: 6, failed: %0d, errors: %0d", failed_tests, error_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, results stopped arriving", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : exec_tb

/* tests/exec_properties.sv */
`timescale 1ns/1ps

module exec_properties import exec_pkg::*; (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                alu_valid_i,
    input logic                commit_valid_i,
    input logic                writeback_valid_i,
    input logic [CREDIT_W-1:0] queue_count_i,
    input logic                result_valid_i,
    input logic                issue_credit_i
);

    int failure_count = 0;  // Failed assertions so far.

    queue_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        queue_count_i <= CREDIT_W'(QUEUE_DEPTH))
        else begin
            $error("Result queue holds %0d entries", queue_count_i);
            failure_count++;
        end

    // Issue credits bound everything in flight plus queued.
    in_flight_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        int'(alu_valid_i) + int'(commit_valid_i) + int'(writeback_valid_i)
        + int'(queue_count_i) <= QUEUE_DEPTH)
        else begin
            $error("More results in flight and queued than issue credits");
            failure_count++;
        end

    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> !(result_valid_i || issue_credit_i || commit_valid_i || writeback_valid_i))
        else begin
            $error("Valid output high during reset");
            failure_count++;
        end

endmodule : exec_properties

/* hdl/exec_top.sv */
`timescale 1ns/1ps

module exec_top import exec_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // Issue side.
    input  logic             issue_valid_i,
    input  alu_op_t          issue_op_i,
    input  logic [REG_W-1:0] issue_src_a_i,
    input  logic [REG_W-1:0] issue_src_b_i,
    input  logic [REG_W-1:0] issue_dest_i,
    input  logic             issue_use_imm_i,
    input  logic [XLEN-1:0]  issue_imm_i,
    output logic             issue_credit_o,

    // Result side.
    input  logic             result_credit_i,
    output logic             result_valid_o,
    output logic [REG_W-1:0] result_dest_o,
    output logic [XLEN-1:0]  result_data_o
);

    logic [XLEN-1:0]  rf_data_a;
    logic [XLEN-1:0]  rf_data_b;
    logic [XLEN-1:0]  operand_a;
    logic [XLEN-1:0]  operand_b;
    logic             alu_valid;
    logic [REG_W-1:0] alu_dest;
    logic [XLEN-1:0]  alu_result;
    logic             commit_valid;
    logic [REG_W-1:0] commit_dest;
    logic [XLEN-1:0]  commit_result;
    logic             writeback_valid;
    logic [REG_W-1:0] writeback_dest;
    logic [XLEN-1:0]  writeback_result;
    logic             rf_wr_en;
    logic [REG_W-1:0] rf_wr_addr;
    logic [XLEN-1:0]  rf_wr_data;

    register_file u_register_file (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_addr_a_i (issue_src_a_i),
        .rd_addr_b_i (issue_src_b_i),
        .rd_data_a_o (rf_data_a),
        .rd_data_b_o (rf_data_b),
        .wr_en_i     (rf_wr_en),
        .wr_addr_i   (rf_wr_addr),
        .wr_data_i   (rf_wr_data)
    );

    forwarding_unit u_forwarding_unit (
        .reg_src_a_i           (issue_src_a_i),
        .reg_src_b_i           (issue_src_b_i),
        .reg_fetch_operand_a_i (rf_data_a),
        .reg_fetch_operand_b_i (rf_data_b),
        .alu_valid_i           (alu_valid),
        .alu_reg_dest_i        (alu_dest),
        .alu_operand_i         (alu_result),
        .commit_valid_i        (commit_valid),
        .commit_reg_dest_i     (commit_dest),
        .commit_operand_i      (commit_result),
        .writeback_valid_i     (writeback_valid),
        .writeback_reg_dest_i  (writeback_dest),
        .writeback_operand_i   (writeback_result),
        .operand_a_o           (operand_a),
        .operand_b_o           (operand_b)
    );

    alu_stage u_alu_stage (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .issue_valid_i   (issue_valid_i),
        .issue_op_i      (issue_op_i),
        .issue_dest_i    (issue_dest_i),
        .issue_use_imm_i (issue_use_imm_i),
        .issue_imm_i     (issue_imm_i),
        .operand_a_i     (operand_a),
        .operand_b_i     (operand_b),
        .alu_valid_o     (alu_valid),
        .alu_dest_o      (alu_dest),
        .alu_result_o    (alu_result)
    );

    retire_stage u_retire_stage (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .alu_valid_i        (alu_valid),
        .alu_dest_i         (alu_dest),
        .alu_result_i       (alu_result),
        .commit_valid_o     (commit_valid),
        .commit_dest_o      (commit_dest),
        .commit_result_o    (commit_result),
        .writeback_valid_o  (writeback_valid),
        .writeback_dest_o   (writeback_dest),
        .writeback_result_o (writeback_result),
        .rf_wr_en_o         (rf_wr_en),
        .rf_wr_addr_o       (rf_wr_addr),
        .rf_wr_data_o       (rf_wr_data),
        .result_credit_i    (result_credit_i),
        .result_valid_o     (result_valid_o),
        .result_dest_o      (result_dest_o),
        .result_data_o      (result_data_o),
        .issue_credit_o     (issue_credit_o)
    );

endmodule : exec_top

/* hdl/retire_stage.sv */
`timescale 1ns/1ps

module retire_stage import exec_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // From the ALU register.
    input  logic             alu_valid_i,
    input  logic [REG_W-1:0] alu_dest_i,
    input  logic [XLEN-1:0]  alu_result_i,

    // Commit and writeback registers, also used for forwarding.
    output logic             commit_valid_o,
    output logic [REG_W-1:0] commit_dest_o,
    output logic [XLEN-1:0]  commit_result_o,
    output logic             writeback_valid_o,
    output logic [REG_W-1:0] writeback_dest_o,
    output logic [XLEN-1:0]  writeback_result_o,

    // Register file write.
    output logic             rf_wr_en_o,
    output logic [REG_W-1:0] rf_wr_addr_o,
    output logic [XLEN-1:0]  rf_wr_data_o,

    // Result side.
    input  logic             result_credit_i,
    output logic             result_valid_o,
    output logic [REG_W-1:0] result_dest_o,
    output logic [XLEN-1:0]  result_data_o,

    output logic             issue_credit_o  // One credit back to the issuer.
);

    logic [REG_W-1:0]       queue_dest [QUEUE_DEPTH];
    logic [XLEN-1:0]        queue_data [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [CREDIT_W-1:0]    queue_count;        // Results waiting in the queue.
    logic [CREDIT_W-1:0]    out_credit_count;   // Credits granted by the consumer.
    logic                   push;
    logic                   pop;

    // Retiring result is written and queued in the same cycle.
    assign push = writeback_valid_o;
    assign pop  = (queue_count != '0) && (out_credit_count != '0);

    assign rf_wr_en_o   = writeback_valid_o;
    assign rf_wr_addr_o = writeback_dest_o;
    assign rf_wr_data_o = writeback_result_o;

    assign result_valid_o = pop;
    assign result_dest_o  = queue_dest[rd_ptr];
    assign result_data_o  = queue_data[rd_ptr];
    assign issue_credit_o = pop;  // Each pop frees one queue slot.

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_valid_o    <= 1'b0;
            writeback_valid_o <= 1'b0;
        end else begin
            commit_valid_o    <= alu_valid_i;
            writeback_valid_o <= commit_valid_o;
        end
    end

    always_ff @(posedge clk_i) begin
        commit_dest_o      <= alu_dest_i;
        commit_result_o    <= alu_result_i;
        writeback_dest_o   <= commit_dest_o;
        writeback_result_o <= commit_result_o;
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_dest[wr_ptr] <= writeback_dest_o;
            queue_data[wr_ptr] <= writeback_result_o;
        end
    end

    // Pointers, occupancy and the output credit counter.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            queue_count      <= '0;
            out_credit_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            queue_count      <= queue_count + CREDIT_W'(push) - CREDIT_W'(pop);
            out_credit_count <= out_credit_count + CREDIT_W'(result_credit_i)
                                - CREDIT_W'(pop);
        end
    end

endmodule : retire_stage

/* hdl/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage import exec_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // Issued instruction.
    input  logic             issue_valid_i,
    input  alu_op_t          issue_op_i,
    input  logic [REG_W-1:0] issue_dest_i,
    input  logic             issue_use_imm_i,
    input  logic [XLEN-1:0]  issue_imm_i,

    // Forwarded operands.
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,

    // ALU pipeline register.
    output logic             alu_valid_o,
    output logic [REG_W-1:0] alu_dest_o,
    output logic [XLEN-1:0]  alu_result_o
);

    logic [XLEN-1:0] src_b;
    logic [4:0]      shamt;
    logic            less_than;
    logic [XLEN-1:0] result;

    assign src_b     = issue_use_imm_i ? issue_imm_i : operand_b_i;
    assign shamt     = src_b[4:0];  // Only the low 5 bits shift.
    assign less_than = $signed(operand_a_i) < $signed(src_b);

    always_comb begin
        case (issue_op_i)
            ADD:     result = operand_a_i + src_b;
            SUB:     result = operand_a_i - src_b;
            AND:     result = operand_a_i & src_b;
            OR:      result = operand_a_i | src_b;
            XOR:     result = operand_a_i ^ src_b;
            SLL:     result = operand_a_i << shamt;
            SRL:     result = operand_a_i >> shamt;
            SLT:     result = {{(XLEN-1){1'b0}}, less_than};
            default: result = '0;
        endcase
    end

    // Valid bit.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_valid_o <= 1'b0;
        end else begin
            alu_valid_o <= issue_valid_i;
        end
    end

    // Payload, qualified downstream by alu_valid_o.
    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            alu_dest_o   <= issue_dest_i;
            alu_result_o <= result;
        end
    end

endmodule : alu_stage

/* hdl/forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit import exec_pkg::*; (
    // Issue source registers.
    input  logic [REG_W-1:0] reg_src_a_i,
    input  logic [REG_W-1:0] reg_src_b_i,

    // Operands read from the register file.
    input  logic [XLEN-1:0]  reg_fetch_operand_a_i,
    input  logic [XLEN-1:0]  reg_fetch_operand_b_i,

    // ALU stage, youngest result.
    input  logic             alu_valid_i,
    input  logic [REG_W-1:0] alu_reg_dest_i,
    input  logic [XLEN-1:0]  alu_operand_i,

    // Commit stage.
    input  logic             commit_valid_i,
    input  logic [REG_W-1:0] commit_reg_dest_i,
    input  logic [XLEN-1:0]  commit_operand_i,

    // Writeback stage, oldest result still in flight.
    input  logic             writeback_valid_i,
    input  logic [REG_W-1:0] writeback_reg_dest_i,
    input  logic [XLEN-1:0]  writeback_operand_i,

    // Operands for the ALU.
    output logic [XLEN-1:0]  operand_a_o,
    output logic [XLEN-1:0]  operand_b_o
);

    logic alu_match_a, commit_match_a, writeback_match_a;
    logic alu_match_b, commit_match_b, writeback_match_b;

    // A stage matches only when it holds a valid result for a nonzero source.
    assign alu_match_a       = alu_valid_i && (alu_reg_dest_i == reg_src_a_i)
                               && (reg_src_a_i != '0);
    assign commit_match_a    = commit_valid_i && (commit_reg_dest_i == reg_src_a_i)
                               && (reg_src_a_i != '0);
    assign writeback_match_a = writeback_valid_i && (writeback_reg_dest_i == reg_src_a_i)
                               && (reg_src_a_i != '0);

    assign alu_match_b       = alu_valid_i && (alu_reg_dest_i == reg_src_b_i)
                               && (reg_src_b_i != '0);
    assign commit_match_b    = commit_valid_i && (commit_reg_dest_i == reg_src_b_i)
                               && (reg_src_b_i != '0);
    assign writeback_match_b = writeback_valid_i && (writeback_reg_dest_i == reg_src_b_i)
                               && (reg_src_b_i != '0);

    // Earlier stage holds the younger value, so it wins.
    always_comb begin : forward_a
        casez ({alu_match_a, commit_match_a, writeback_match_a})
            3'b1??:  operand_a_o = alu_operand_i;
            3'b01?:  operand_a_o = commit_operand_i;
            3'b001:  operand_a_o = writeback_operand_i;
            default: operand_a_o = reg_fetch_operand_a_i;  // No hazard.
        endcase
    end : forward_a

    always_comb begin : forward_b
        casez ({alu_match_b, commit_match_b, writeback_match_b})
            3'b1??:  operand_b_o = alu_operand_i;
            3'b01?:  operand_b_o = commit_operand_i;
            3'b001:  operand_b_o = writeback_operand_i;
            default: operand_b_o = reg_fetch_operand_b_i;
        endcase
    end : forward_b

endmodule : forwarding_unit

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file import exec_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,

    // Read ports.
    input  logic [REG_W-1:0] rd_addr_a_i,
    input  logic [REG_W-1:0] rd_addr_b_i,
    output logic [XLEN-1:0]  rd_data_a_o,
    output logic [XLEN-1:0]  rd_data_b_o,

    // Write port.
    input  logic             wr_en_i,
    input  logic [REG_W-1:0] wr_addr_i,
    input  logic [XLEN-1:0]  wr_data_i
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin  // x0 writes are dropped.
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Asynchronous reads, x0 is hardwired to zero.
    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs[rd_addr_b_i];

endmodule : register_file

/* hdl/exec_pkg.sv */
package exec_pkg;

    // Datapath and register index widths.
    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    localparam int NUM_REGS = 2 ** REG_W;  // Architectural registers, x0 included.

    // Result queue depth, equal to the issue credits handed out after reset.
    localparam int QUEUE_DEPTH = 4;

    // Counter width able to hold QUEUE_DEPTH.
    localparam int CREDIT_W = 3;

    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);  // Queue index width.

    // ALU operation encoding.
    // Shifts use the low 5 bits of operand B, SLT is a signed compare.
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_t;

endpackage : exec_pkg
